//--- rtl/lar_settings.svh
`ifndef LAR_SETTINGS_SVH
`define LAR_SETTINGS_SVH

// number of load-address registers
`define LAR_COUNT 8

// must cover LAR_COUNT entries
`define LAR_INDEX_W 3

// one LAR data word, also one RAM word
`define DATA_W 64

// data RAM size in words
`define RAM_DEPTH 256

// word address width, must cover RAM_DEPTH
`define RAM_ADDR_W 8

`endif

//--- rtl/lar_pkg.sv
`include "lar_settings.svh"

package lar_pkg;

	typedef logic [`LAR_INDEX_W-1:0] lar_index_t;
	typedef logic [`DATA_W-1:0] data_word_t;
	typedef logic [`RAM_ADDR_W-1:0] mem_addr_t;

	// 0 alu, 1 no write, 2 load, 3 store
	typedef logic [1:0] instr_group_t;

	// bit 0 selects signed, bits 2:1 give the size
	// stores in group 3 use the same codes
	typedef enum logic [3:0]
	{
		LdU8 = 4'd0,
		LdS8 = 4'd1,
		LdU16 = 4'd2,
		LdS16 = 4'd3,
		LdU32 = 4'd4,
		LdS32 = 4'd5,
		LdU64 = 4'd6,
		LdS64 = 4'd7,
		LdF16 = 4'd8
	} ldst_op_t;

	typedef enum logic [1:0]
	{
		WriteOnlyData = 2'd0,
		WriteLd = 2'd1,
		WriteSt = 2'd2
	} write_type_t;

	typedef enum logic [1:0]
	{
		DataUnsgnInt = 2'd0,
		DataSgnInt = 2'd1,
		DataBFloat16 = 2'd2
	} data_type_t;

	typedef enum logic [1:0]
	{
		Sz8 = 2'd0,
		Sz16 = 2'd1,
		Sz32 = 2'd2,
		Sz64 = 2'd3
	} int_size_t;

	typedef enum logic
	{
		StRegular = 1'b0,
		StWaitValid = 1'b1
	} wb_state_t;

endpackage

//--- rtl/data_ram.sv
`include "lar_settings.svh"

module data_ram
(
	input logic clk,
	input logic en,
	input logic we,
	input lar_pkg::mem_addr_t addr,
	input lar_pkg::data_word_t wdata,
	output lar_pkg::data_word_t rdata
);

	lar_pkg::data_word_t mem [`RAM_DEPTH];

	// single port, whole words only
	always_ff @(posedge clk)
	begin
		if (en)
		begin
			if (we)
				mem[addr] <= wdata;
			// read-first, a write returns the old word
			rdata <= mem[addr];
		end
	end

endmodule

//--- rtl/lar_file.sv
`include "lar_settings.svh"

module lar_file
(
	input logic clk,
	input logic reset,
	input logic wr_req,
	input lar_pkg::write_type_t wr_write_type,
	input lar_pkg::lar_index_t wr_index,
	input lar_pkg::data_word_t wr_data,
	input lar_pkg::mem_addr_t wr_ldst_addr,
	input lar_pkg::data_type_t wr_data_type,
	input lar_pkg::int_size_t wr_int_size,
	output logic wr_valid,
	input lar_pkg::lar_index_t rd_index,
	output lar_pkg::data_word_t rd_data,
	output lar_pkg::mem_addr_t rd_addr,
	output lar_pkg::data_type_t rd_data_type,
	output lar_pkg::int_size_t rd_int_size,
	output logic ram_en,
	output logic ram_we,
	output lar_pkg::mem_addr_t ram_addr,
	output lar_pkg::data_word_t ram_wdata,
	input lar_pkg::data_word_t ram_rdata
);

	typedef enum logic [1:0]
	{
		SeqIdle,
		SeqMem,
		SeqDone
	} seq_state_t;

	seq_state_t seq_state;
	logic start_ldst;

	lar_pkg::data_word_t lar_data [`LAR_COUNT];
	lar_pkg::mem_addr_t lar_addr [`LAR_COUNT];
	lar_pkg::data_type_t lar_type [`LAR_COUNT];
	lar_pkg::int_size_t lar_size [`LAR_COUNT];

	// transaction captured at the request edge
	lar_pkg::lar_index_t cap_index;
	lar_pkg::mem_addr_t cap_addr;
	lar_pkg::data_type_t cap_type;
	lar_pkg::int_size_t cap_size;
	logic cap_is_load;

	function automatic lar_pkg::data_word_t extend_load(input lar_pkg::data_word_t raw,
		input lar_pkg::data_type_t dtype, input lar_pkg::int_size_t size);
		logic sgn;
		lar_pkg::data_word_t result;
		sgn = (dtype == lar_pkg::DataSgnInt);
		result = raw;
		if (dtype == lar_pkg::DataBFloat16)
			result = {{(`DATA_W-16){1'b0}}, raw[15:0]};
		else
		begin
			case (size)
				lar_pkg::Sz8:
					result = {{(`DATA_W-8){sgn & raw[7]}}, raw[7:0]};
				lar_pkg::Sz16:
					result = {{(`DATA_W-16){sgn & raw[15]}}, raw[15:0]};
				lar_pkg::Sz32:
					result = {{(`DATA_W-32){sgn & raw[31]}}, raw[31:0]};
				default:
					result = raw;
			endcase
		end
		return result;
	endfunction

	assign start_ldst = wr_req && (seq_state == SeqIdle)
		&& ((wr_write_type == lar_pkg::WriteLd) || (wr_write_type == lar_pkg::WriteSt));

	// RAM is driven straight from the request so read data is back next cycle
	assign ram_en = start_ldst;
	assign ram_we = start_ldst && (wr_write_type == lar_pkg::WriteSt);
	assign ram_addr = wr_ldst_addr;
	assign ram_wdata = lar_data[wr_index];

	assign wr_valid = (seq_state == SeqDone);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			seq_state <= SeqIdle;
			for (int i = 0; i < `LAR_COUNT; i++)
			begin
				lar_data[i] <= '0;
				lar_addr[i] <= '0;
				lar_type[i] <= lar_pkg::DataUnsgnInt;
				lar_size[i] <= lar_pkg::Sz64;
			end
		end
		else
		begin
			case (seq_state)
				SeqIdle:
				begin
					if (start_ldst)
						seq_state <= SeqMem;
					else if (wr_req && (wr_write_type == lar_pkg::WriteOnlyData))
						lar_data[wr_index] <= wr_data;
				end
				SeqMem:
				begin
					// stores keep the data, only the tag fields change
					if (cap_is_load)
						lar_data[cap_index] <= extend_load(ram_rdata, cap_type, cap_size);
					lar_addr[cap_index] <= cap_addr;
					lar_type[cap_index] <= cap_type;
					lar_size[cap_index] <= cap_size;
					seq_state <= SeqDone;
				end
				default:
					seq_state <= SeqIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (start_ldst)
		begin
			cap_index <= wr_index;
			cap_addr <= wr_ldst_addr;
			cap_type <= wr_data_type;
			cap_size <= wr_int_size;
			cap_is_load <= (wr_write_type == lar_pkg::WriteLd);
		end
	end

	// operand read port
	assign rd_data = lar_data[rd_index];
	assign rd_addr = lar_addr[rd_index];
	assign rd_data_type = lar_type[rd_index];
	assign rd_int_size = lar_size[rd_index];

endmodule

//--- rtl/wb_stage.sv
module wb_stage
(
	input logic clk,
	input logic reset,
	input lar_pkg::instr_group_t group,
	input lar_pkg::ldst_op_t oper,
	input lar_pkg::lar_index_t ra_index,
	input lar_pkg::data_word_t computed_data,
	input lar_pkg::mem_addr_t ldst_addr,
	input logic wr_valid,
	output logic stall,
	output logic wr_req,
	output lar_pkg::write_type_t wr_write_type,
	output lar_pkg::lar_index_t wr_index,
	output lar_pkg::data_word_t wr_data,
	output lar_pkg::mem_addr_t wr_ldst_addr,
	output lar_pkg::data_type_t wr_data_type,
	output lar_pkg::int_size_t wr_int_size
);

	lar_pkg::wb_state_t state;
	lar_pkg::wb_state_t next_state;
	logic is_ldst;
	lar_pkg::data_type_t dec_type;
	lar_pkg::int_size_t dec_size;

	// groups 2 and 3 go through memory
	assign is_ldst = (group == 2'd2) || (group == 2'd3);

	always_comb
	begin
		case (state)
			lar_pkg::StRegular:
				next_state = is_ldst ? lar_pkg::StWaitValid : lar_pkg::StRegular;
			lar_pkg::StWaitValid:
				next_state = wr_valid ? lar_pkg::StRegular : lar_pkg::StWaitValid;
			default:
				next_state = lar_pkg::StRegular;
		endcase
	end

	// front of the pipe holds while a transaction is in flight
	assign stall = (next_state == lar_pkg::StWaitValid);

	// loads and stores share one encoding, so one decode serves both
	always_comb
	begin
		if (oper == lar_pkg::LdF16)
		begin
			dec_type = lar_pkg::DataBFloat16;
			// bfloat16 is always a 16-bit value
			dec_size = lar_pkg::Sz16;
		end
		else
		begin
			dec_type = oper[0] ? lar_pkg::DataSgnInt : lar_pkg::DataUnsgnInt;
			dec_size = lar_pkg::int_size_t'(oper[2:1]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= lar_pkg::StRegular;
			wr_req <= 1'b0;
		end
		else
		begin
			state <= next_state;
			// one request per instruction, none while waiting
			wr_req <= (state == lar_pkg::StRegular) && (group != 2'd1);
		end
	end

	// request payload, sampled alongside wr_req
	always_ff @(posedge clk)
	begin
		if (state == lar_pkg::StRegular)
		begin
			case (group)
				2'd0: wr_write_type <= lar_pkg::WriteOnlyData;
				2'd2: wr_write_type <= lar_pkg::WriteLd;
				2'd3: wr_write_type <= lar_pkg::WriteSt;
				default: wr_write_type <= wr_write_type;
			endcase
			wr_index <= ra_index;
			wr_data <= computed_data;
			wr_ldst_addr <= ldst_addr;
			wr_data_type <= dec_type;
			wr_int_size <= dec_size;
		end
	end

endmodule

//--- rtl/wb_subsystem.sv
module wb_subsystem
(
	input logic clk,
	input logic reset,
	input lar_pkg::instr_group_t group,
	input lar_pkg::ldst_op_t oper,
	input lar_pkg::lar_index_t ra_index,
	input lar_pkg::data_word_t computed_data,
	input lar_pkg::mem_addr_t ldst_addr,
	output logic stall,
	input lar_pkg::lar_index_t rd_index,
	output lar_pkg::data_word_t rd_data,
	output lar_pkg::mem_addr_t rd_addr,
	output lar_pkg::data_type_t rd_data_type,
	output lar_pkg::int_size_t rd_int_size
);

	// writeback to LAR file request
	logic wr_req;
	logic wr_valid;
	lar_pkg::write_type_t wr_write_type;
	lar_pkg::lar_index_t wr_index;
	lar_pkg::data_word_t wr_data;
	lar_pkg::mem_addr_t wr_ldst_addr;
	lar_pkg::data_type_t wr_data_type;
	lar_pkg::int_size_t wr_int_size;

	// LAR file to RAM
	logic ram_en;
	logic ram_we;
	lar_pkg::mem_addr_t ram_addr;
	lar_pkg::data_word_t ram_wdata;
	lar_pkg::data_word_t ram_rdata;

	wb_stage wb_stage0
	(
		.clk(clk),
		.reset(reset),
		.group(group),
		.oper(oper),
		.ra_index(ra_index),
		.computed_data(computed_data),
		.ldst_addr(ldst_addr),
		.wr_valid(wr_valid),
		.stall(stall),
		.wr_req(wr_req),
		.wr_write_type(wr_write_type),
		.wr_index(wr_index),
		.wr_data(wr_data),
		.wr_ldst_addr(wr_ldst_addr),
		.wr_data_type(wr_data_type),
		.wr_int_size(wr_int_size)
	);

	lar_file lar_file0
	(
		.clk(clk),
		.reset(reset),
		.wr_req(wr_req),
		.wr_write_type(wr_write_type),
		.wr_index(wr_index),
		.wr_data(wr_data),
		.wr_ldst_addr(wr_ldst_addr),
		.wr_data_type(wr_data_type),
		.wr_int_size(wr_int_size),
		.wr_valid(wr_valid),
		.rd_index(rd_index),
		.rd_data(rd_data),
		.rd_addr(rd_addr),
		.rd_data_type(rd_data_type),
		.rd_int_size(rd_int_size),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata)
	);

	data_ram data_ram0
	(
		.clk(clk),
		.en(ram_en),
		.we(ram_we),
		.addr(ram_addr),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

endmodule

//--- tb/wb_assertions.sv
module wb_assertions
(
	input logic clk,
	input logic reset,
	input logic wr_req,
	input logic wr_valid,
	input lar_pkg::write_type_t wr_write_type,
	input logic stall
);

	logic ldst_open;
	logic [7:0] stall_run;

	// a load or store is in flight between its request and its valid
	always_ff @(posedge clk)
	begin
		if (reset)
			ldst_open <= 1'b0;
		else if (wr_valid)
			ldst_open <= 1'b0;
		else if (wr_req && (wr_write_type != lar_pkg::WriteOnlyData))
			ldst_open <= 1'b1;
	end

	// consecutive rising edges with stall high
	always_ff @(posedge clk)
	begin
		if (reset)
			stall_run <= '0;
		else if (stall)
			stall_run <= stall_run + 8'd1;
		else
			stall_run <= '0;
	end

	valid_needs_ldst: assert property (@(posedge clk) disable iff (reset)
		wr_valid |-> ldst_open)
		else $error("wr_valid without an open load or store request");

	req_is_pulse: assert property (@(posedge clk) disable iff (reset)
		wr_req |=> !wr_req)
		else $error("wr_req high for two cycles in a row");

	stall_bounded: assert property (@(posedge clk) disable iff (reset)
		stall |-> (stall_run < 8'd8))
		else $error("stall stayed high for more than 8 cycles");

endmodule

//--- tb/wb_tb.sv
`include "lar_settings.svh"

module wb_tb;

	localparam int HALF_PERIOD = 10;
	localparam int MAX_ENTRIES = 64;
	localparam int CYCLES_PER_ENTRY = 8;
	localparam int EXTRA_CYCLES = 50;
	localparam int LDST_STALL_CYCLES = 3;
	// top bit of every integer size
	localparam lar_pkg::data_word_t SIGN_BITS = 64'h8000_0000_8000_8080;

	logic clk = 1'b0;
	logic reset;
	lar_pkg::instr_group_t group;
	lar_pkg::ldst_op_t oper;
	lar_pkg::lar_index_t ra_index;
	lar_pkg::data_word_t computed_data;
	lar_pkg::mem_addr_t ldst_addr;
	logic stall;
	lar_pkg::lar_index_t rd_index;
	lar_pkg::data_word_t rd_data;
	lar_pkg::mem_addr_t rd_addr;
	lar_pkg::data_type_t rd_data_type;
	lar_pkg::int_size_t rd_int_size;

	// stimulus table
	lar_pkg::instr_group_t t_group [MAX_ENTRIES];
	lar_pkg::ldst_op_t t_oper [MAX_ENTRIES];
	lar_pkg::lar_index_t t_index [MAX_ENTRIES];
	lar_pkg::data_word_t t_data [MAX_ENTRIES];
	lar_pkg::mem_addr_t t_addr [MAX_ENTRIES];
	// expected target LAR after each entry
	lar_pkg::data_word_t e_data [MAX_ENTRIES];
	lar_pkg::mem_addr_t e_addr [MAX_ENTRIES];
	lar_pkg::data_type_t e_type [MAX_ENTRIES];
	lar_pkg::int_size_t e_size [MAX_ENTRIES];
	logic e_ldst [MAX_ENTRIES];
	int n_entries;

	// reference model of the LARs and the RAM
	lar_pkg::data_word_t m_data [`LAR_COUNT];
	lar_pkg::mem_addr_t m_addr [`LAR_COUNT];
	lar_pkg::data_type_t m_type [`LAR_COUNT];
	lar_pkg::int_size_t m_size [`LAR_COUNT];
	lar_pkg::data_word_t m_ram [`RAM_DEPTH];

	logic [31:0] lfsr_state = 32'hb662;
	int cycle_count = 0;
	int cycle_limit = 0;

	wb_subsystem dut0
	(
		.clk(clk),
		.reset(reset),
		.group(group),
		.oper(oper),
		.ra_index(ra_index),
		.computed_data(computed_data),
		.ldst_addr(ldst_addr),
		.stall(stall),
		.rd_index(rd_index),
		.rd_data(rd_data),
		.rd_addr(rd_addr),
		.rd_data_type(rd_data_type),
		.rd_int_size(rd_int_size)
	);

	bind wb_subsystem wb_assertions wb_assertions0
	(
		.clk(clk),
		.reset(reset),
		.wr_req(wr_req),
		.wr_valid(wr_valid),
		.wr_write_type(wr_write_type),
		.stall(stall)
	);

	always #(HALF_PERIOD) clk = ~clk;

	task automatic stop_run();
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	always @(posedge clk)
	begin
		cycle_count++;
		if ((cycle_limit > 0) && (cycle_count > cycle_limit))
		begin
			$display("timeout: run went past %0d cycles without finishing", cycle_limit);
			stop_run();
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_next_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic lar_pkg::data_word_t random_bits(input int nbits);
		lar_pkg::data_word_t w;
		w = '0;
		for (int b = 0; b < nbits; b++)
			w = {w[`DATA_W-2:0], lfsr_next_bit()};
		return w;
	endfunction

	function automatic lar_pkg::data_type_t model_type(input lar_pkg::ldst_op_t op);
		case (op)
			lar_pkg::LdS8, lar_pkg::LdS16, lar_pkg::LdS32, lar_pkg::LdS64:
				return lar_pkg::DataSgnInt;
			lar_pkg::LdF16:
				return lar_pkg::DataBFloat16;
			default:
				return lar_pkg::DataUnsgnInt;
		endcase
	endfunction

	function automatic lar_pkg::int_size_t model_size(input lar_pkg::ldst_op_t op);
		case (op)
			lar_pkg::LdU8, lar_pkg::LdS8:
				return lar_pkg::Sz8;
			lar_pkg::LdU16, lar_pkg::LdS16, lar_pkg::LdF16:
				return lar_pkg::Sz16;
			lar_pkg::LdU32, lar_pkg::LdS32:
				return lar_pkg::Sz32;
			default:
				return lar_pkg::Sz64;
		endcase
	endfunction

	function automatic lar_pkg::data_word_t model_extend(input lar_pkg::data_word_t raw,
		input lar_pkg::data_type_t dt, input lar_pkg::int_size_t sz);
		int nbits;
		lar_pkg::data_word_t mask;
		lar_pkg::data_word_t value;
		if (dt == lar_pkg::DataBFloat16)
			return raw & 64'h0000_0000_0000_ffff;
		case (sz)
			lar_pkg::Sz8: nbits = 8;
			lar_pkg::Sz16: nbits = 16;
			lar_pkg::Sz32: nbits = 32;
			default: nbits = `DATA_W;
		endcase
		if (nbits == `DATA_W)
			return raw;
		mask = (lar_pkg::data_word_t'(1) << nbits) - lar_pkg::data_word_t'(1);
		value = raw & mask;
		if ((dt == lar_pkg::DataSgnInt) && raw[nbits-1])
			value = value | ~mask;
		return value;
	endfunction

	// appends one entry and runs it through the model for its expected values
	task automatic add_entry(input lar_pkg::instr_group_t g, input lar_pkg::ldst_op_t op,
		input lar_pkg::lar_index_t idx, input lar_pkg::data_word_t data,
		input lar_pkg::mem_addr_t addr);
		lar_pkg::data_type_t dt;
		lar_pkg::int_size_t sz;
		int n;
		n = n_entries;
		t_group[n] = g;
		t_oper[n] = op;
		t_index[n] = idx;
		t_data[n] = data;
		t_addr[n] = addr;
		dt = model_type(op);
		sz = model_size(op);
		case (g)
			2'd0:
				m_data[idx] = data;
			2'd2:
			begin
				m_data[idx] = model_extend(m_ram[addr], dt, sz);
				m_addr[idx] = addr;
				m_type[idx] = dt;
				m_size[idx] = sz;
			end
			2'd3:
			begin
				m_ram[addr] = m_data[idx];
				m_addr[idx] = addr;
				m_type[idx] = dt;
				m_size[idx] = sz;
			end
			default:
				;
		endcase
		e_data[n] = m_data[idx];
		e_addr[n] = m_addr[idx];
		e_type[n] = m_type[idx];
		e_size[n] = m_size[idx];
		e_ldst[n] = (g == 2'd2) || (g == 2'd3);
		n_entries = n + 1;
	endtask

	task automatic build_table();
		lar_pkg::data_word_t d;
		lar_pkg::mem_addr_t st_addr [`LAR_COUNT];
		for (int i = 0; i < `LAR_COUNT; i++)
		begin
			m_data[i] = '0;
			m_addr[i] = '0;
			m_type[i] = lar_pkg::DataUnsgnInt;
			m_size[i] = lar_pkg::Sz64;
		end
		// even LARs get every sign bit set, odd ones get them cleared
		for (int i = 0; i < `LAR_COUNT; i++)
		begin
			d = random_bits(`DATA_W);
			d = (i % 2 == 0) ? (d | SIGN_BITS) : (d & ~SIGN_BITS);
			add_entry(2'd0, lar_pkg::LdU64, lar_pkg::lar_index_t'(i), d, '0);
		end
		add_entry(2'd1, lar_pkg::LdS64, 3'd2, random_bits(`DATA_W), 8'h11);
		// low address bits are the LAR index, so all store addresses differ
		for (int i = 0; i < `LAR_COUNT; i++)
		begin
			d = (random_bits(`RAM_ADDR_W) << `LAR_INDEX_W) | lar_pkg::data_word_t'(i);
			st_addr[i] = lar_pkg::mem_addr_t'(d);
			add_entry(2'd3, lar_pkg::ldst_op_t'(4'(i)), lar_pkg::lar_index_t'(i),
				random_bits(`DATA_W), st_addr[i]);
		end
		// every load kind, once from a word with sign bits set and once without
		for (int k = 0; k < 9; k++)
			add_entry(2'd2, lar_pkg::ldst_op_t'(4'(k)), lar_pkg::lar_index_t'((k + 3) % 8),
				random_bits(`DATA_W), st_addr[k % 8]);
		for (int k = 0; k < 9; k++)
			add_entry(2'd2, lar_pkg::ldst_op_t'(4'(k)), lar_pkg::lar_index_t'((k + 5) % 8),
				random_bits(`DATA_W), st_addr[(k + 1) % 8]);
		add_entry(2'd3, lar_pkg::LdF16, 3'd5, random_bits(`DATA_W), st_addr[0]);
		add_entry(2'd1, lar_pkg::LdU8, 3'd5, random_bits(`DATA_W), st_addr[1]);
		// back to back on one LAR
		add_entry(2'd0, lar_pkg::LdU64, 3'd6, random_bits(`DATA_W) | SIGN_BITS, '0);
		add_entry(2'd3, lar_pkg::LdS8, 3'd6, '0, st_addr[2]);
		add_entry(2'd2, lar_pkg::LdS16, 3'd6, '0, st_addr[2]);
		add_entry(2'd3, lar_pkg::LdU32, 3'd6, '0, st_addr[3]);
		add_entry(2'd2, lar_pkg::LdS64, 3'd6, '0, st_addr[3]);
		add_entry(2'd2, lar_pkg::LdF16, 3'd6, '0, st_addr[4]);
		add_entry(2'd0, lar_pkg::LdU8, 3'd0, random_bits(`DATA_W), '0);
	endtask

	task automatic check_data(input string name, input lar_pkg::data_word_t got,
		input lar_pkg::data_word_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input lar_pkg::mem_addr_t got,
		input lar_pkg::mem_addr_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_type(input string name, input lar_pkg::data_type_t got,
		input lar_pkg::data_type_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_size(input string name, input lar_pkg::int_size_t got,
		input lar_pkg::int_size_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_stall(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_lar(input lar_pkg::data_word_t exp_data,
		input lar_pkg::mem_addr_t exp_addr, input lar_pkg::data_type_t exp_type,
		input lar_pkg::int_size_t exp_size);
		check_data("rd_data", rd_data, exp_data);
		check_addr("rd_addr", rd_addr, exp_addr);
		check_type("rd_data_type", rd_data_type, exp_type);
		check_size("rd_int_size", rd_int_size, exp_size);
	endtask

	// starts on a falling edge and ends on one
	task automatic run_entry(input int n);
		logic seen;
		int high_cycles;
		group = t_group[n];
		oper = t_oper[n];
		ra_index = t_index[n];
		computed_data = t_data[n];
		ldst_addr = t_addr[n];
		high_cycles = 0;
		while (1)
		begin
			// sample just ahead of the rising edge
			#(HALF_PERIOD - 1);
			seen = stall;
			check_stall("stall", seen, e_ldst[n] && (high_cycles < LDST_STALL_CYCLES));
			@(posedge clk);
			if (!seen)
				break;
			high_cycles++;
			@(negedge clk);
		end
		@(negedge clk);
		group = 2'd1;
		rd_index = t_index[n];
		@(posedge clk);
		@(posedge clk);
		@(negedge clk);
		check_lar(e_data[n], e_addr[n], e_type[n], e_size[n]);
		check_stall("stall", stall, 1'b0);
	endtask

	initial
	begin
		reset = 1'b1;
		group = 2'd1;
		oper = lar_pkg::LdU8;
		ra_index = '0;
		computed_data = '0;
		ldst_addr = '0;
		rd_index = '0;
		n_entries = 0;
		build_table();
		cycle_limit = n_entries * CYCLES_PER_ENTRY + EXTRA_CYCLES;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// every LAR at its reset value
		for (int i = 0; i < `LAR_COUNT; i++)
		begin
			rd_index = lar_pkg::lar_index_t'(i);
			@(negedge clk);
			check_lar('0, '0, lar_pkg::DataUnsgnInt, lar_pkg::Sz64);
			check_stall("stall", stall, 1'b0);
		end

		for (int n = 0; n < n_entries; n++)
			run_entry(n);

		// nothing else moved
		for (int i = 0; i < `LAR_COUNT; i++)
		begin
			rd_index = lar_pkg::lar_index_t'(i);
			@(negedge clk);
			check_lar(m_data[i], m_addr[i], m_type[i], m_size[i]);
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- flist.f
+incdir+rtl
rtl/lar_pkg.sv
rtl/data_ram.sv
rtl/lar_file.sv
rtl/wb_stage.sv
rtl/wb_subsystem.sv
tb/wb_assertions.sv
tb/wb_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= wb_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
